/* hbm_rd_front.f */
source/hbm_axi_pkg.sv
source/hbm_csr_pkg.sv
source/hbm_axi_slice.sv
source/hbm_ar_splitter.sv
source/hbm_rlast_filter.sv
source/hbm_stat_csr.sv
source/hbm_rd_front.sv
test/hbm_rd_front_assertions.sv
test/hbm_rd_front_tb.sv

/* source/hbm_ar_splitter.sv */
module hbm_ar_splitter
  import hbm_axi_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  // axi4 ar from the host
  input  logic                  i_ar_valid,
  input  logic [ADDR_W-1:0]     i_ar_addr,
  input  logic [ID_W-1:0]       i_ar_id,
  input  logic [AXI4_LEN_W-1:0] i_ar_len,
  output logic                  o_ar_ready,
  // axi3 sub-bursts toward the memory
  output logic                  o_sub_valid,
  output ar_payload_t           o_sub,
  input  logic                  i_sub_ready,
  // one flag per sub-burst into the rlast filter
  output logic                  o_flag_valid,
  output logic                  o_flag_last,
  input  logic                  i_flag_ready
);

  // address advance between sub-bursts, 512 bytes
  localparam logic [ADDR_W-1:0]     SUB_STEP    = ADDR_W'(SUB_BEATS * BEAT_BYTES);
  localparam logic [AXI4_LEN_W-1:0] SUB_LEN_MAX = AXI4_LEN_W'(SUB_BEATS - 1);
  localparam logic [AXI4_LEN_W-1:0] SUB_LEN_DEC = AXI4_LEN_W'(SUB_BEATS);

  logic                  busy;       // a host burst is being split
  logic [ADDR_W-1:0]     cur_addr;   // address of the next sub-burst
  logic [ID_W-1:0]       cur_id;
  logic [AXI4_LEN_W-1:0] rem_len;    // beats left minus one
  logic                  final_sub;  // the offered sub-burst ends the host burst
  logic                  ar_fire;
  logic                  sub_fire;

  assign final_sub = (rem_len <= SUB_LEN_MAX);

  assign o_ar_ready = ~busy;                  // one host burst at a time
  assign ar_fire    = i_ar_valid & o_ar_ready;

  // offer only with room for the flag, so the push never waits
  assign o_sub_valid = busy & i_flag_ready;
  assign sub_fire    = o_sub_valid & i_sub_ready;

  // ========================================
  // sub-burst payload
  // ========================================
  assign o_sub.addr = cur_addr;
  assign o_sub.id   = cur_id;
  assign o_sub.len  = final_sub ? rem_len[AXI3_LEN_W-1:0] : AXI3_LEN_W'(SUB_BEATS - 1);
  assign o_sub.size = AXSIZE_FULL;            // forced to full width

  // flag travels with the accepted sub-burst
  assign o_flag_valid = sub_fire;
  assign o_flag_last  = final_sub;

  // ========================================
  // burst state
  // ========================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy <= 1'b0;
    end else if (ar_fire) begin
      busy <= 1'b1;
    end else if (sub_fire && final_sub) begin
      busy <= 1'b0;                           // back to idle after the last piece
    end
  end

  always_ff @(posedge clk) begin
    if (ar_fire) begin
      cur_addr <= i_ar_addr;
      cur_id   <= i_ar_id;
      rem_len  <= i_ar_len;
    end else if (sub_fire) begin
      cur_addr <= cur_addr + SUB_STEP;        // incr bursts only
      rem_len  <= rem_len - SUB_LEN_DEC;      // wraps only on the final piece
    end
  end

endmodule

/* source/hbm_axi_pkg.sv */
package hbm_axi_pkg;

  // ========================================
  // bus widths
  // ========================================
  localparam int ADDR_W     = 34;   // memory byte address
  localparam int ID_W       = 6;    // transaction id
  localparam int DATA_W     = 256;  // one beat
  localparam int RESP_W     = 2;    // rresp

  localparam int AXI4_LEN_W = 8;    // host side arlen, up to 256 beats
  localparam int AXI3_LEN_W = 4;    // memory side arlen, up to 16 beats

  // ========================================
  // beat geometry
  // ========================================
  localparam int BEAT_BYTES = DATA_W / 8;  // 32 bytes per beat
  localparam int SUB_BEATS  = 16;          // beats in a full axi3 sub-burst

  // only full-width beats are issued
  localparam logic [2:0] AXSIZE_FULL = 3'd5;

  // ========================================
  // channel payloads
  // ========================================
  typedef struct packed {
    logic [ADDR_W-1:0]     addr;  // first byte of the sub-burst
    logic [ID_W-1:0]       id;    // echoed on every r beat
    logic [AXI3_LEN_W-1:0] len;   // beats minus one
    logic [2:0]            size;  // always AXSIZE_FULL
  } ar_payload_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [ID_W-1:0]   id;
    logic [RESP_W-1:0] resp;
    logic              last;      // end of the host burst
  } r_payload_t;

endpackage

/* source/hbm_axi_slice.sv */
module hbm_axi_slice #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  // upstream
  input  logic     i_valid,
  input  payload_t i_data,
  output logic     o_ready,
  // downstream
  output logic     o_valid,
  output payload_t o_data,
  input  logic     i_ready
);

  logic     out_valid;   // main register holds a beat
  payload_t out_data;
  logic     skid_valid;  // overflow register holds a beat
  payload_t skid_data;
  logic     in_fire;
  logic     out_free;

  assign o_ready  = ~skid_valid;            // registered, breaks the ready path
  assign in_fire  = i_valid & o_ready;
  assign out_free = ~out_valid | i_ready;   // main register drains or is empty

  assign o_valid = out_valid;
  assign o_data  = out_data;

  // ========================================
  // occupancy
  // ========================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
    end else if (out_free) begin
      out_valid  <= skid_valid | in_fire;   // refill from skid first
      skid_valid <= 1'b0;                   // skid always empties here
    end else if (in_fire) begin
      skid_valid <= 1'b1;                   // downstream stalled, park the beat
    end
  end

  // payload registers
  always_ff @(posedge clk) begin
    if (out_free) begin
      out_data <= skid_valid ? skid_data : i_data;  // keeps beat order
    end
    if (in_fire && !out_free) begin
      skid_data <= i_data;
    end
  end

endmodule

/* source/hbm_csr_pkg.sv */
package hbm_csr_pkg;

  // ========================================
  // status bus geometry
  // ========================================
  localparam int CSR_ADDR_W      = 32;   // host byte address
  localparam int CSR_DATA_W      = 32;   // read and write data
  localparam int CSR_DECODE_BITS = 8;    // only low address bits are decoded

  // ========================================
  // register map
  // ========================================
  localparam logic [CSR_DECODE_BITS-1:0] CSR_CTRL_ADDR = 8'h00;  // control and status word

  // bit positions inside the control word
  localparam int CSR_BIT_SOFT_RST = 0;   // r/w, 1 holds the memory in reset
  localparam int CSR_BIT_INIT_LSB = 1;   // r/o, one init-done bit per stack from here up

  // returned for any address outside the map
  localparam logic [CSR_DATA_W-1:0] CSR_BAD_READ = 32'hdead_dead;

endpackage

/* source/hbm_rd_front.sv */
module hbm_rd_front
  import hbm_axi_pkg::*;
  import hbm_csr_pkg::*;
#(
  parameter int NUM_STACKS  = 2,
  parameter int SYNC_STAGES = 2,
  parameter int FLAG_DEPTH  = 8
) (
  input  logic                  clk,
  input  logic                  rst_n,
  // host ar, axi4
  input  logic                  i_ar_valid,
  input  logic [ADDR_W-1:0]     i_ar_addr,
  input  logic [ID_W-1:0]       i_ar_id,
  input  logic [AXI4_LEN_W-1:0] i_ar_len,
  output logic                  o_ar_ready,
  // host r
  output logic                  o_r_valid,
  output logic [DATA_W-1:0]     o_r_data,
  output logic [ID_W-1:0]       o_r_id,
  output logic [RESP_W-1:0]     o_r_resp,
  output logic                  o_r_last,
  input  logic                  i_r_ready,
  // memory ar, axi3
  output logic                  o_mem_ar_valid,
  output logic [ADDR_W-1:0]     o_mem_ar_addr,
  output logic [ID_W-1:0]       o_mem_ar_id,
  output logic [AXI3_LEN_W-1:0] o_mem_ar_len,
  output logic [2:0]            o_mem_ar_size,
  input  logic                  i_mem_ar_ready,
  // memory r
  input  logic                  i_mem_r_valid,
  input  logic [DATA_W-1:0]     i_mem_r_data,
  input  logic [ID_W-1:0]       i_mem_r_id,
  input  logic [RESP_W-1:0]     i_mem_r_resp,
  input  logic                  i_mem_r_last,
  output logic                  o_mem_r_ready,
  // status bus
  input  logic                  i_stat_wr,
  input  logic                  i_stat_rd,
  input  logic [CSR_ADDR_W-1:0] i_stat_addr,
  input  logic [CSR_DATA_W-1:0] i_stat_wdata,
  output logic                  o_stat_ack,
  output logic [CSR_DATA_W-1:0] o_stat_rdata,
  input  logic [NUM_STACKS-1:0] i_init_done,
  output logic                  o_mem_rst_n,
  output logic                  o_hbm_ready
);

  ar_payload_t sub_ar;        // splitter to ar slice
  logic        sub_valid;
  logic        sub_ready;
  ar_payload_t mem_ar;        // ar slice to memory pins
  logic        flag_valid;
  logic        flag_last;
  logic        flag_ready;
  r_payload_t  flt_r;         // filter to r slice
  logic        flt_valid;
  logic        flt_ready;
  r_payload_t  host_r;        // r slice to host pins

  // ========================================
  // status and reset
  // ========================================
  hbm_stat_csr #(
    .NUM_STACKS  (NUM_STACKS),
    .SYNC_STAGES (SYNC_STAGES)
  ) u_stat_csr (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_stat_wr    (i_stat_wr),
    .i_stat_rd    (i_stat_rd),
    .i_stat_addr  (i_stat_addr),
    .i_stat_wdata (i_stat_wdata),
    .o_stat_ack   (o_stat_ack),
    .o_stat_rdata (o_stat_rdata),
    .i_init_done  (i_init_done),
    .o_mem_rst_n  (o_mem_rst_n),
    .o_hbm_ready  (o_hbm_ready)
  );

  // ========================================
  // ar path
  // ========================================
  hbm_ar_splitter u_splitter (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_ar_valid   (i_ar_valid),
    .i_ar_addr    (i_ar_addr),
    .i_ar_id      (i_ar_id),
    .i_ar_len     (i_ar_len),
    .o_ar_ready   (o_ar_ready),
    .o_sub_valid  (sub_valid),
    .o_sub        (sub_ar),
    .i_sub_ready  (sub_ready),
    .o_flag_valid (flag_valid),
    .o_flag_last  (flag_last),
    .i_flag_ready (flag_ready)
  );

  hbm_axi_slice #(.payload_t(ar_payload_t)) u_ar_slice (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_valid (sub_valid),
    .i_data  (sub_ar),
    .o_ready (sub_ready),
    .o_valid (o_mem_ar_valid),
    .o_data  (mem_ar),
    .i_ready (i_mem_ar_ready)
  );

  assign o_mem_ar_addr = mem_ar.addr;
  assign o_mem_ar_id   = mem_ar.id;
  assign o_mem_ar_len  = mem_ar.len;
  assign o_mem_ar_size = mem_ar.size;   // full width from the splitter

  // ========================================
  // r path
  // ========================================
  hbm_rlast_filter #(.FLAG_DEPTH(FLAG_DEPTH)) u_filter (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_flag_valid  (flag_valid),
    .i_flag_last   (flag_last),
    .o_flag_ready  (flag_ready),
    .i_mem_r_valid (i_mem_r_valid),
    .i_mem_r_data  (i_mem_r_data),
    .i_mem_r_id    (i_mem_r_id),
    .i_mem_r_resp  (i_mem_r_resp),
    .i_mem_r_last  (i_mem_r_last),
    .o_mem_r_ready (o_mem_r_ready),
    .o_r_valid     (flt_valid),
    .o_r           (flt_r),
    .i_r_ready     (flt_ready)
  );

  hbm_axi_slice #(.payload_t(r_payload_t)) u_r_slice (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_valid (flt_valid),
    .i_data  (flt_r),
    .o_ready (flt_ready),
    .o_valid (o_r_valid),
    .o_data  (host_r),
    .i_ready (i_r_ready)
  );

  assign o_r_data = host_r.data;
  assign o_r_id   = host_r.id;
  assign o_r_resp = host_r.resp;
  assign o_r_last = host_r.last;

endmodule

/* source/hbm_rlast_filter.sv */
module hbm_rlast_filter
  import hbm_axi_pkg::*;
#(
  parameter int FLAG_DEPTH = 8
) (
  input  logic              clk,
  input  logic              rst_n,
  // flag push from the splitter
  input  logic              i_flag_valid,
  input  logic              i_flag_last,
  output logic              o_flag_ready,
  // axi3 r from the memory
  input  logic              i_mem_r_valid,
  input  logic [DATA_W-1:0] i_mem_r_data,
  input  logic [ID_W-1:0]   i_mem_r_id,
  input  logic [RESP_W-1:0] i_mem_r_resp,
  input  logic              i_mem_r_last,
  output logic              o_mem_r_ready,
  // filtered r toward the host
  output logic              o_r_valid,
  output r_payload_t        o_r,
  input  logic              i_r_ready
);

  localparam int PTR_W = (FLAG_DEPTH > 1) ? $clog2(FLAG_DEPTH) : 1;
  localparam int CNT_W = $clog2(FLAG_DEPTH + 1);

  logic [FLAG_DEPTH-1:0] flag_mem;    // one last flag per sub-burst in flight
  logic [PTR_W-1:0]      wr_ptr;
  logic [PTR_W-1:0]      rd_ptr;
  logic [CNT_W-1:0]      count;
  logic                  fifo_empty;
  logic                  hold_last;
  logic                  push;
  logic                  pop;

  assign fifo_empty   = (count == '0);
  assign o_flag_ready = (count != CNT_W'(FLAG_DEPTH));
  assign push         = i_flag_valid & o_flag_ready;

  // ========================================
  // beat pass-through
  // ========================================
  assign hold_last     = i_mem_r_last & fifo_empty;  // last beat ahead of its flag
  assign o_r_valid     = i_mem_r_valid & ~hold_last;
  assign o_mem_r_ready = i_r_ready & ~hold_last;     // host stall reaches the memory
  assign pop           = i_mem_r_valid & o_mem_r_ready & i_mem_r_last;

  assign o_r.data = i_mem_r_data;
  assign o_r.id   = i_mem_r_id;
  assign o_r.resp = i_mem_r_resp;
  assign o_r.last = i_mem_r_last & flag_mem[rd_ptr];  // masked on inner sub-bursts

  // ========================================
  // flag fifo
  // ========================================
  always_ff @(posedge clk) begin
    if (push) begin
      flag_mem[wr_ptr] <= i_flag_last;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(FLAG_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(FLAG_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;          // idle or push and pop together
      endcase
    end
  end

endmodule

/* source/hbm_stat_csr.sv */
module hbm_stat_csr
  import hbm_csr_pkg::*;
#(
  parameter int NUM_STACKS  = 2,
  parameter int SYNC_STAGES = 2
) (
  input  logic                  clk,
  input  logic                  rst_n,
  // status bus
  input  logic                  i_stat_wr,
  input  logic                  i_stat_rd,
  input  logic [CSR_ADDR_W-1:0] i_stat_addr,
  input  logic [CSR_DATA_W-1:0] i_stat_wdata,
  output logic                  o_stat_ack,
  output logic [CSR_DATA_W-1:0] o_stat_rdata,
  // memory status and control
  input  logic [NUM_STACKS-1:0] i_init_done,
  output logic                  o_mem_rst_n,
  output logic                  o_hbm_ready
);

  logic                       wr_q;
  logic                       rd_q;
  logic [CSR_DECODE_BITS-1:0] addr_q;
  logic [CSR_DATA_W-1:0]      wdata_q;
  logic                       ctrl_hit;
  logic                       soft_rst;     // host-held memory reset
  logic [NUM_STACKS-1:0]      init_sync [SYNC_STAGES];
  logic [NUM_STACKS-1:0]      init_done_s;
  logic [CSR_DATA_W-1:0]      ctrl_word;

  // ========================================
  // bus input register
  // ========================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_q       <= 1'b0;
      rd_q       <= 1'b0;
      o_stat_ack <= 1'b0;
    end else begin
      wr_q       <= i_stat_wr;
      rd_q       <= i_stat_rd;
      o_stat_ack <= wr_q | rd_q;      // one pulse, two cycles after the strobe
    end
  end

  always_ff @(posedge clk) begin
    addr_q  <= i_stat_addr[CSR_DECODE_BITS-1:0];
    wdata_q <= i_stat_wdata;
  end

  assign ctrl_hit = (addr_q == CSR_CTRL_ADDR);

  // soft reset bit
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      soft_rst <= 1'b0;
    end else if (wr_q && ctrl_hit) begin
      soft_rst <= wdata_q[CSR_BIT_SOFT_RST];
    end
  end

  // read word for csr 0
  always_comb begin
    ctrl_word = '0;
    ctrl_word[CSR_BIT_SOFT_RST] = soft_rst;
    ctrl_word[CSR_BIT_INIT_LSB +: NUM_STACKS] = init_done_s;
  end

  always_ff @(posedge clk) begin
    if (wr_q || rd_q) begin
      o_stat_rdata <= ctrl_hit ? ctrl_word : CSR_BAD_READ;
    end
  end

  // ========================================
  // init done and readiness
  // ========================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int s = 0; s < SYNC_STAGES; s++) begin
        init_sync[s] <= '0;
      end
    end else begin
      init_sync[0] <= i_init_done;
      for (int s = 1; s < SYNC_STAGES; s++) begin
        init_sync[s] <= init_sync[s-1];   // shift toward the core
      end
    end
  end

  assign init_done_s = init_sync[SYNC_STAGES-1];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_hbm_ready <= 1'b0;
      o_mem_rst_n <= 1'b0;              // memory held while the system resets
    end else begin
      o_hbm_ready <= &init_done_s;      // every stack must report
      o_mem_rst_n <= ~soft_rst;
    end
  end

endmodule

/* test/hbm_rd_front_assertions.sv */
module hbm_rd_front_assertions
  import hbm_axi_pkg::*;
(
  input logic                  clk,
  input logic                  rst_n,
  input logic                  i_ar_valid,
  input logic                  o_ar_ready,
  input logic                  o_r_valid,
  input logic [DATA_W-1:0]     o_r_data,
  input logic [ID_W-1:0]       o_r_id,
  input logic [RESP_W-1:0]     o_r_resp,
  input logic                  o_r_last,
  input logic                  i_r_ready,
  input logic                  o_mem_ar_valid,
  input logic [ADDR_W-1:0]     o_mem_ar_addr,
  input logic [ID_W-1:0]       o_mem_ar_id,
  input logic [AXI3_LEN_W-1:0] o_mem_ar_len,
  input logic [2:0]            o_mem_ar_size,
  input logic                  i_mem_ar_ready,
  input logic                  i_mem_r_valid,
  input logic                  o_mem_r_ready,
  input logic                  i_stat_wr,
  input logic                  i_stat_rd,
  input logic                  o_stat_ack,
  input logic                  o_mem_rst_n,
  input logic                  o_hbm_ready
);

  int fail_count = 0;   // read by the testbench at the end of the run
  int held;             // beats inside the r slice
  int ar_count;         // host bursts accepted
  int last_count;       // host bursts closed by rlast

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      held       <= 0;
      ar_count   <= 0;
      last_count <= 0;
    end else begin
      held <= held + ((i_mem_r_valid && o_mem_r_ready) ? 1 : 0)
                   - ((o_r_valid && i_r_ready) ? 1 : 0);
      if (i_ar_valid && o_ar_ready) ar_count <= ar_count + 1;
      if (o_r_valid && i_r_ready && o_r_last) last_count <= last_count + 1;
    end
  end

  // ========================================
  // reset and status bus
  // ========================================
  a_reset_state: assert property (@(posedge clk) !rst_n |=>
      !o_mem_ar_valid && !o_r_valid && !o_stat_ack && !o_hbm_ready && !o_mem_rst_n)
    else begin fail_count++; $error("outputs not idle after reset"); end

  a_ack_delay: assert property (@(posedge clk) disable iff (!rst_n)
      (i_stat_wr || i_stat_rd) |-> ##2 o_stat_ack)
    else begin fail_count++; $error("status ack not two cycles after strobe"); end

  a_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n) o_stat_ack |=> !o_stat_ack)
    else begin fail_count++; $error("status ack longer than one cycle"); end

  // ========================================
  // channel stability and beat accounting
  // ========================================
  a_mem_ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
      o_mem_ar_valid && !i_mem_ar_ready |=> o_mem_ar_valid &&
      $stable({o_mem_ar_addr, o_mem_ar_id, o_mem_ar_len, o_mem_ar_size}))
    else begin fail_count++; $error("memory ar changed while stalled"); end

  a_mem_ar_size: assert property (@(posedge clk) disable iff (!rst_n)
      o_mem_ar_valid |-> o_mem_ar_size == 3'd5)   // 32-byte beats
    else begin fail_count++; $error("memory ar size is not full width"); end

  a_r_stable: assert property (@(posedge clk) disable iff (!rst_n)
      o_r_valid && !i_r_ready |=> o_r_valid && $stable({o_r_data, o_r_id, o_r_resp, o_r_last}))
    else begin fail_count++; $error("host r changed while stalled"); end

  a_beat_balance: assert property (@(posedge clk) disable iff (!rst_n)
      held >= 0 && held <= 2 && ((held != 0) == o_r_valid))
    else begin fail_count++; $error("r beat lost or duplicated"); end

  a_one_last: assert property (@(posedge clk) disable iff (!rst_n) last_count <= ar_count)
    else begin fail_count++; $error("more rlast beats than host bursts"); end

endmodule

bind hbm_rd_front hbm_rd_front_assertions u_assert (.*);

/* test/hbm_rd_front_tb.sv */
module hbm_rd_front_tb
  import hbm_axi_pkg::*;
  import hbm_csr_pkg::*;
;

  localparam int SYNC_STAGES    = 2;
  localparam int TIMEOUT_CYCLES = 20000;  // test 5 dominates, about 700 beats, ready low a third

  typedef struct {
    logic [ADDR_W-1:0]     addr;
    logic [ID_W-1:0]       id;
    logic [AXI4_LEN_W-1:0] len;
  } burst_t;

  logic                  clk;
  logic                  rst_n;
  logic                  i_ar_valid;
  logic [ADDR_W-1:0]     i_ar_addr;
  logic [ID_W-1:0]       i_ar_id;
  logic [AXI4_LEN_W-1:0] i_ar_len;
  logic                  o_ar_ready;
  logic                  o_r_valid;
  logic [DATA_W-1:0]     o_r_data;
  logic [ID_W-1:0]       o_r_id;
  logic [RESP_W-1:0]     o_r_resp;
  logic                  o_r_last;
  logic                  i_r_ready;
  logic                  o_mem_ar_valid;
  logic [ADDR_W-1:0]     o_mem_ar_addr;
  logic [ID_W-1:0]       o_mem_ar_id;
  logic [AXI3_LEN_W-1:0] o_mem_ar_len;
  logic [2:0]            o_mem_ar_size;
  logic                  i_mem_ar_ready;
  logic                  i_mem_r_valid;
  logic [DATA_W-1:0]     i_mem_r_data;
  logic [ID_W-1:0]       i_mem_r_id;
  logic [RESP_W-1:0]     i_mem_r_resp;
  logic                  i_mem_r_last;
  logic                  o_mem_r_ready;
  logic                  i_stat_wr;
  logic                  i_stat_rd;
  logic [CSR_ADDR_W-1:0] i_stat_addr;
  logic [CSR_DATA_W-1:0] i_stat_wdata;
  logic                  o_stat_ack;
  logic [CSR_DATA_W-1:0] o_stat_rdata;
  logic [1:0]            i_init_done;
  logic                  o_mem_rst_n;
  logic                  o_hbm_ready;

  burst_t      host_q[$];     // host bursts still returning beats
  ar_payload_t sub_exp_q[$];  // sub-bursts predicted from the split rule
  ar_payload_t mem_q[$];      // sub-bursts the memory has accepted
  int          host_beat;     // beat index inside host_q[0]
  int          sub_count;
  int          checks;
  int          errors;
  int          cycle_cnt;
  bit          mem_r_fire;    // memory beat taken at the last edge
  bit          stress;        // heavy ready gaps

  hbm_rd_front #(
    .NUM_STACKS  (2),
    .SYNC_STAGES (SYNC_STAGES),
    .FLAG_DEPTH  (8)
  ) uut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, a handshake never completed", cycle_cnt);
      $display("Verification failed");
      $finish;
    end
  end

  // ========================================
  // checks and reference model
  // ========================================
  function automatic int error_total();
    return errors + uut.u_assert.fail_count;
  endfunction

  function automatic logic [DATA_W-1:0] beat_pattern(input logic [ADDR_W-1:0] addr);
    return {30'd0, addr[33:32], {7{addr[31:0]}}};  // low word repeated, top bits last
  endfunction

  function automatic logic [ADDR_W-1:0] random_addr();
    logic [63:0] r;
    r = {$urandom(), $urandom()};
    return r[ADDR_W-1:0] & ~ADDR_W'(BEAT_BYTES - 1);  // beat aligned
  endfunction

  task automatic check_value(input string name, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("Error: %s expected 0x%0h got 0x%0h", name, exp, got);
      errors++;
    end
  endtask

  task automatic check_sub_burst();
    ar_payload_t s;
    sub_count++;
    checks++;
    assert (sub_exp_q.size() != 0) else begin
      $display("memory ar issued while no sub-burst was expected");
      errors++;
    end
    if (sub_exp_q.size() != 0) begin
      s = sub_exp_q.pop_front();
      check_value("o_mem_ar_addr", o_mem_ar_addr, s.addr);
      check_value("o_mem_ar_id", o_mem_ar_id, s.id);
      check_value("o_mem_ar_len", o_mem_ar_len, s.len);
      check_value("o_mem_ar_size", o_mem_ar_size, s.size);
    end
    s.addr = o_mem_ar_addr;        // memory answers what it was asked
    s.id   = o_mem_ar_id;
    s.len  = o_mem_ar_len;
    s.size = o_mem_ar_size;
    mem_q.push_back(s);
  endtask

  task automatic check_host_beat();
    burst_t            b;
    logic [ADDR_W-1:0] a;
    checks++;
    assert (host_q.size() != 0) else begin
      $display("beat on o_r while no host burst was outstanding");
      errors++;
    end
    if (host_q.size() != 0) begin
      b = host_q[0];
      a = b.addr + ADDR_W'(host_beat * BEAT_BYTES);
      check_value("o_r_data", o_r_data, beat_pattern(a));
      check_value("o_r_id", o_r_id, b.id);
      check_value("o_r_resp", o_r_resp, a[6:5]);
      check_value("o_r_last", o_r_last, host_beat == int'(b.len));
      if (host_beat == int'(b.len)) begin
        void'(host_q.pop_front());
        host_beat = 0;
      end else begin
        host_beat++;
      end
    end
  endtask

  // handshakes sampled on the rising edge, before the DUT registers update
  always @(posedge clk) begin
    mem_r_fire = rst_n && i_mem_r_valid && o_mem_r_ready;
    if (rst_n && o_mem_ar_valid && i_mem_ar_ready) check_sub_burst();
    if (rst_n && o_r_valid && i_r_ready) check_host_beat();
  end

  // ========================================
  // memory responder and ready gaps
  // ========================================
  task automatic drive_mem_beat(input ar_payload_t s, input int k);
    logic [ADDR_W-1:0] a;
    a             = s.addr + ADDR_W'(k * BEAT_BYTES);
    i_mem_r_valid = 1'b1;
    i_mem_r_data  = beat_pattern(a);
    i_mem_r_id    = s.id;
    i_mem_r_resp  = a[6:5];                 // resp follows the beat address
    i_mem_r_last  = (k == int'(s.len));
  endtask

  task automatic respond_reads();
    ar_payload_t cur;
    int          beat;
    bit          busy;
    busy = 1'b0;
    beat = 0;
    forever begin
      @(negedge clk);
      if (mem_r_fire) begin
        if (beat == int'(cur.len)) begin
          busy          = 1'b0;
          i_mem_r_valid = 1'b0;
          i_mem_r_last  = 1'b0;
        end else begin
          beat++;
          drive_mem_beat(cur, beat);
        end
      end
      if (!busy && mem_q.size() != 0 && $urandom_range(1) == 0) begin
        cur  = mem_q.pop_front();
        busy = 1'b1;
        beat = 0;
        drive_mem_beat(cur, beat);
      end
    end
  endtask

  task automatic drive_ready_gaps();
    forever begin
      @(negedge clk);
      if (stress) begin
        i_r_ready      = ($urandom_range(2) != 0);
        i_mem_ar_ready = ($urandom_range(2) != 0);
      end else begin
        i_r_ready      = 1'b1;
        i_mem_ar_ready = ($urandom_range(3) != 0);  // short accept delay
      end
    end
  endtask

  // ========================================
  // host side stimulus
  // ========================================
  task automatic send_burst(input logic [ADDR_W-1:0] addr, input logic [ID_W-1:0] id,
                            input logic [AXI4_LEN_W-1:0] len);
    burst_t      b;
    ar_payload_t s;
    int          n;
    b.addr = addr;
    b.id   = id;
    b.len  = len;
    host_q.push_back(b);
    n = int'(len) / SUB_BEATS + 1;
    for (int k = 0; k < n; k++) begin
      s.addr = addr + ADDR_W'(k * SUB_BEATS * BEAT_BYTES);  // 512 bytes apart
      s.id   = id;
      s.len  = (k == n - 1) ? AXI3_LEN_W'(len % 16) : 4'd15;
      s.size = 3'd5;
      sub_exp_q.push_back(s);
    end
    @(negedge clk);
    i_ar_valid = 1'b1;
    i_ar_addr  = addr;
    i_ar_id    = id;
    i_ar_len   = len;
    do @(posedge clk); while (!o_ar_ready);
    @(negedge clk);
    i_ar_valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (host_q.size() != 0 || sub_exp_q.size() != 0 || mem_q.size() != 0) begin
      @(negedge clk);
    end
  endtask

  task automatic csr_access(input logic wr, input logic [CSR_ADDR_W-1:0] addr,
                            input logic [CSR_DATA_W-1:0] wdata,
                            output logic [CSR_DATA_W-1:0] rdata);
    int waited;
    @(negedge clk);
    i_stat_wr    = wr;
    i_stat_rd    = ~wr;
    i_stat_addr  = addr;
    i_stat_wdata = wdata;
    @(negedge clk);
    i_stat_wr = 1'b0;
    i_stat_rd = 1'b0;
    waited    = 1;
    while (!o_stat_ack && waited < 8) begin
      @(negedge clk);
      waited++;
    end
    rdata = o_stat_rdata;
    checks++;
    assert (o_stat_ack) else begin
      $display("status bus gave no ack within 8 cycles");
      errors++;
    end
    check_value("o_stat_ack latency", waited, 2);
  endtask

  task automatic csr_read(input logic [CSR_ADDR_W-1:0] addr, input logic [CSR_DATA_W-1:0] exp);
    logic [CSR_DATA_W-1:0] rdata;
    csr_access(1'b0, addr, '0, rdata);
    check_value("o_stat_rdata", rdata, exp);
  endtask

  task automatic csr_write_rst(input logic bit_val);
    logic [CSR_DATA_W-1:0] rdata;
    logic                  exp_rst_n;
    int                    waited;
    exp_rst_n = ~bit_val;                   // memory reset is active low
    csr_access(1'b1, 32'h0, {31'd0, bit_val}, rdata);
    waited = 0;
    while (o_mem_rst_n !== exp_rst_n && waited < 4) begin
      @(negedge clk);
      waited++;
    end
    check_value("o_mem_rst_n", o_mem_rst_n, exp_rst_n);
    check_value("o_mem_rst_n delay", waited, 1);  // registered output
  endtask

  task automatic report_test(input int num, input string name, input int err_before);
    $display("test %0d %s: %0d errors", num, name, error_total() - err_before);
  endtask

  // ========================================
  // test sequence
  // ========================================
  initial begin
    int                    err_start;
    int                    waited;
    int                    sub_before;
    logic [ADDR_W-1:0]     a;
    logic [ID_W-1:0]       id;
    logic [AXI4_LEN_W-1:0] len;
    void'($urandom(22));
    rst_n          = 1'b0;
    i_ar_valid     = 1'b0;
    i_ar_addr      = '0;
    i_ar_id        = '0;
    i_ar_len       = '0;
    i_r_ready      = 1'b1;
    i_mem_ar_ready = 1'b1;
    i_mem_r_valid  = 1'b0;
    i_mem_r_data   = '0;
    i_mem_r_id     = '0;
    i_mem_r_resp   = '0;
    i_mem_r_last   = 1'b0;
    i_stat_wr      = 1'b0;
    i_stat_rd      = 1'b0;
    i_stat_addr    = '0;
    i_stat_wdata   = '0;
    i_init_done    = 2'b00;
    stress         = 1'b0;
    fork
      respond_reads();
      drive_ready_gaps();
    join_none
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    err_start = error_total();
    check_value("o_ar_ready", o_ar_ready, 1);
    csr_read(32'h0, 32'h0);
    csr_write_rst(1'b1);
    csr_read(32'h0, 32'h1);
    csr_write_rst(1'b0);
    csr_read(32'h0, 32'h0);
    csr_read(32'h10, 32'hdead_dead);
    report_test(1, "status bus and soft reset", err_start);

    err_start = error_total();
    @(negedge clk);
    i_init_done = 2'b01;
    repeat (SYNC_STAGES + 3) begin
      @(negedge clk);
      check_value("o_hbm_ready", o_hbm_ready, 0);  // one stack is not enough
    end
    csr_read(32'h0, 32'h2);
    @(negedge clk);
    i_init_done = 2'b11;
    waited      = 0;
    while (!o_hbm_ready && waited < 10) begin
      @(negedge clk);
      waited++;
    end
    check_value("o_hbm_ready delay", waited, SYNC_STAGES + 1);
    csr_read(32'h0, 32'h6);
    report_test(2, "readiness", err_start);

    err_start = error_total();
    for (int i = 0; i < 6; i++) begin
      a   = random_addr();
      id  = ID_W'($urandom_range(63));
      len = (i == 0) ? 8'd0 : (i == 1) ? 8'd15 : AXI4_LEN_W'($urandom_range(14));
      send_burst(a, id, len);
    end
    wait_drain();
    report_test(3, "single sub-burst reads", err_start);

    err_start  = error_total();
    sub_before = sub_count;
    send_burst(34'h2_0001_0000, 6'h2a, 8'd255);
    wait_drain();
    check_value("sub-burst count", sub_count - sub_before, 16);
    sub_before = sub_count;
    send_burst(34'h0_1234_5600, 6'h15, 8'd39);
    wait_drain();
    check_value("sub-burst count", sub_count - sub_before, 3);
    report_test(4, "long burst split", err_start);

    err_start = error_total();
    stress    = 1'b1;
    for (int i = 0; i < 16; i++) begin
      a   = random_addr();
      id  = ID_W'($urandom_range(63));
      len = AXI4_LEN_W'($urandom_range(79));
      send_burst(a, id, len);
    end
    wait_drain();
    stress = 1'b0;
    report_test(5, "back-to-back under back-pressure", err_start);

    repeat (4) @(negedge clk);
    $display("tests 5, checks %0d, errors %0d", checks, error_total());
    if (error_total() == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule
